// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // release just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== dv/tb_ooo_core.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    // about 360 instructions, five cycles worst case each, doubled
    localparam int INSN_BUDGET = 400;
    localparam int CYCLE_LIMIT = INSN_BUDGET * 10;

    logic  clock, reset;
    logic  insn_valid;
    op_t   insn_op;
    arn_t  insn_dest, insn_src1, insn_src2;
    data_t insn_imm;
    logic  stall, commit_valid;
    arn_t  commit_arn;
    data_t commit_value;

    // program-order model of the architectural registers
    data_t  model_regs [`OOO_ARCH_REGS];
    arn_t   exp_arn [$];
    data_t  exp_val [$];
    int     value_errors, other_errors;
    int     accepted, committed, cycle;
    logic   was_reset, stall_seen;
    integer seed;

    tb_clock_gen i_clock_gen (.clock(clock), .reset(reset));
    ooo_core     i_dut (.*);

    function automatic data_t expected_result(op_t op, data_t a, data_t b, data_t imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_LI:   return imm;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    task automatic record_commit();
        assert (exp_val.size() != 0) else begin
            other_errors++;
            $display("commit at %0t with no instruction outstanding", $time);
        end
        if (exp_val.size() != 0) begin
            assert (commit_arn == exp_arn[0]) else begin
                value_errors++;
                $display("FAILED t=%0t commit_arn expected %0d got %0d",
                         $time, exp_arn[0], commit_arn);
            end
            assert (commit_value == exp_val[0]) else begin
                value_errors++;
                $display("FAILED t=%0t commit_value expected %h got %h",
                         $time, exp_val[0], commit_value);
            end
            void'(exp_arn.pop_front());
            void'(exp_val.pop_front());
        end
        committed++;
    endtask

    task automatic record_accept();
        data_t result;
        result = expected_result(insn_op, model_regs[insn_src1], model_regs[insn_src2], insn_imm);
        model_regs[insn_dest] = result;
        exp_arn.push_back(insn_dest);
        exp_val.push_back(result);
        accepted++;
    endtask

    // sampled mid-cycle, the values the next rising edge acts on
    always @(negedge clock) begin
        if (reset) begin
            was_reset = 1'b1;
            assert (!stall && !commit_valid) else begin
                other_errors++;
                $display("stall or commit_valid high during reset at %0t", $time);
            end
        end else begin
            if (was_reset) begin
                assert (!stall && !commit_valid) else begin
                    other_errors++;
                    $display("stall or commit_valid high right after reset at %0t", $time);
                end
            end
            was_reset = 1'b0;
            if (stall) stall_seen = 1'b1;
            // more than a full ROB in flight means stall failed to hold
            if (insn_valid && !stall) begin
                assert (accepted - committed < `OOO_ROB_DEPTH) else begin
                    other_errors++;
                    $display("instruction accepted while the ROB was full at %0t", $time);
                end
            end
            if (commit_valid) record_commit();
            if (insn_valid && !stall) record_accept();
        end
    end

    always @(posedge clock) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d instructions committed",
                     cycle, committed, accepted);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // holds the instruction until the edge that accepts it
    task automatic send_insn(op_t op, arn_t dest, arn_t src1, arn_t src2, data_t imm);
        insn_valid = 1'b1;
        insn_op    = op;
        insn_dest  = dest;
        insn_src1  = src1;
        insn_src2  = src2;
        insn_imm   = imm;
        while (stall) begin
            @(posedge clock);
            #1;
        end
        @(posedge clock);
        #1;
        insn_valid = 1'b0;
    endtask

    task automatic read_all_registers();
        for (int r = 0; r < `OOO_ARCH_REGS; r++) begin
            send_insn(OP_ADD, arn_t'(r), arn_t'(r), 3'd0, '0);
        end
    endtask

    task automatic alu_opcodes();
        send_insn(OP_LI, 3'd1, 3'd0, 3'd0, 16'h1234);
        send_insn(OP_LI, 3'd2, 3'd0, 3'd0, 16'h00ff);
        send_insn(OP_ADD, 3'd3, 3'd1, 3'd2, '0);
        send_insn(OP_SUB, 3'd4, 3'd1, 3'd2, '0);
        send_insn(OP_AND, 3'd5, 3'd1, 3'd2, '0);
        send_insn(OP_XOR, 3'd6, 3'd1, 3'd2, '0);
        send_insn(OP_MUL, 3'd7, 3'd1, 3'd2, '0);
    endtask

    task automatic dependency_chains();
        send_insn(OP_LI, 3'd1, 3'd0, 3'd0, 16'd3);
        send_insn(OP_MUL, 3'd2, 3'd1, 3'd1, '0);
        send_insn(OP_ADD, 3'd3, 3'd2, 3'd1, '0);
        send_insn(OP_MUL, 3'd4, 3'd3, 3'd2, '0);
        send_insn(OP_XOR, 3'd5, 3'd4, 3'd1, '0);
        // the li finishes before the multiply ahead of it
        send_insn(OP_MUL, 3'd2, 3'd2, 3'd4, '0);
        send_insn(OP_LI, 3'd6, 3'd0, 3'd0, 16'h0777);
        send_insn(OP_SUB, 3'd7, 3'd2, 3'd6, '0);
    endtask

    task automatic register_reuse();
        send_insn(OP_LI, 3'd2, 3'd0, 3'd0, 16'd1);
        for (int i = 0; i < 20; i++) begin
            send_insn(OP_ADD, 3'd1, 3'd1, 3'd2, '0);
        end
        send_insn(OP_XOR, 3'd3, 3'd1, 3'd0, '0);
        send_insn(OP_ADD, 3'd4, 3'd1, 3'd1, '0);
    endtask

    task automatic fill_until_stall();
        send_insn(OP_LI, 3'd1, 3'd0, 3'd0, 16'd2);
        send_insn(OP_LI, 3'd2, 3'd0, 3'd0, 16'd3);
        stall_seen = 1'b0;
        for (int i = 0; i < 16; i++) begin
            send_insn(OP_MUL, 3'd1, 3'd1, 3'd2, '0);
        end
        assert (stall_seen) else begin
            other_errors++;
            $display("stall never rose during the multiply burst");
        end
    endtask

    task automatic random_stress();
        int gap;
        for (int i = 0; i < 300; i++) begin
            send_insn(op_t'($unsigned($random(seed)) % 6), arn_t'($random(seed)),
                      arn_t'($random(seed)), arn_t'($random(seed)), data_t'($random(seed)));
            if (($random(seed) & 3) == 0) begin
                gap = 1 + $unsigned($random(seed)) % 3;
                repeat (gap) begin
                    @(posedge clock);
                    #1;
                end
            end
        end
    endtask

    initial begin
        seed         = 32'he2cd3b2f;
        insn_valid   = 1'b0;
        insn_op      = OP_ADD;
        insn_dest    = '0;
        insn_src1    = '0;
        insn_src2    = '0;
        insn_imm     = '0;
        value_errors = 0;
        other_errors = 0;
        accepted     = 0;
        committed    = 0;
        cycle        = 0;
        was_reset    = 1'b0;
        stall_seen   = 1'b0;
        for (int r = 0; r < `OOO_ARCH_REGS; r++) model_regs[r] = '0;

        @(negedge reset);
        read_all_registers();
        alu_opcodes();
        dependency_chains();
        register_reuse();
        fill_until_stall();
        random_stress();

        // let everything in flight retire, then watch for strays
        while (exp_val.size() != 0) begin
            @(posedge clock);
            #1;
        end
        repeat (10) @(posedge clock);
        assert (committed == accepted) else begin
            other_errors++;
            $display("%0d instructions accepted but %0d committed", accepted, committed);
        end

        $display("errors: %0d value, %0d other; %0d accepted, %0d committed",
                 value_errors, other_errors, accepted, committed);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== ooo_core.f ====
+incdir+verilog
verilog/ooo_pkg.sv
verilog/rename_stage.sv
verilog/phys_regfile.sv
verilog/reservation_station.sv
verilog/exec_units.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
dv/tb_clock_gen.sv
dv/tb_ooo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ooo_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f ooo_core.f \
        --top-module tb_ooo_core -o tb_ooo_core; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_ooo_core)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== verilog/exec_units.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module exec_units (
    input  logic           clock,
    input  logic           reset,
    input  logic           issue_valid,
    input  ooo_pkg::op_t   issue_op,
    input  ooo_pkg::data_t issue_a, issue_b,
    input  ooo_pkg::prn_t  issue_dest_prn,
    input  ooo_pkg::robn_t issue_robn,
    output logic           issue_ready,
    output logic           cdb_valid,
    output ooo_pkg::prn_t  cdb_prn,
    output ooo_pkg::robn_t cdb_robn,
    output ooo_pkg::data_t cdb_value
);
    import ooo_pkg::*;

    // the data bus register doubles as the final multiply stage
    localparam int MUL_REGS = `OOO_MUL_STAGES - 1;

    logic  mul_valid [MUL_REGS];
    prn_t  mul_prn [MUL_REGS];
    robn_t mul_robn [MUL_REGS];
    data_t mul_value [MUL_REGS];
    data_t alu_result;
    logic  mul_out;
    logic  issue_go;

    // multiplier owns the bus next cycle, hold off new issue
    assign mul_out     = mul_valid[MUL_REGS-1];
    assign issue_ready = !mul_out;
    assign issue_go    = issue_valid && issue_ready;

    always_comb begin
        case (issue_op)
            OP_ADD:  alu_result = issue_a + issue_b;
            OP_SUB:  alu_result = issue_a - issue_b;
            OP_AND:  alu_result = issue_a & issue_b;
            OP_XOR:  alu_result = issue_a ^ issue_b;
            OP_LI:   alu_result = issue_a;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < MUL_REGS; s++) begin
                mul_valid[s] <= 1'b0;
            end
            cdb_valid <= 1'b0;
        end else begin
            mul_valid[0] <= issue_go && issue_op == OP_MUL;
            for (int s = 1; s < MUL_REGS; s++) begin
                mul_valid[s] <= mul_valid[s-1];
            end
            cdb_valid <= mul_out || (issue_go && issue_op != OP_MUL);
        end
    end

    always_ff @(posedge clock) begin
        mul_prn[0]   <= issue_dest_prn;
        mul_robn[0]  <= issue_robn;
        mul_value[0] <= issue_a * issue_b;
        for (int s = 1; s < MUL_REGS; s++) begin
            mul_prn[s]   <= mul_prn[s-1];
            mul_robn[s]  <= mul_robn[s-1];
            mul_value[s] <= mul_value[s-1];
        end
        if (mul_out) begin
            cdb_prn   <= mul_prn[MUL_REGS-1];
            cdb_robn  <= mul_robn[MUL_REGS-1];
            cdb_value <= mul_value[MUL_REGS-1];
        end else begin
            cdb_prn   <= issue_dest_prn;
            cdb_robn  <= issue_robn;
            cdb_value <= alu_result;
        end
    end

endmodule

// ==== verilog/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core (
    input  logic           clock,
    input  logic           reset,
    input  logic           insn_valid,
    input  ooo_pkg::op_t   insn_op,
    input  ooo_pkg::arn_t  insn_dest, insn_src1, insn_src2,
    input  ooo_pkg::data_t insn_imm,
    output logic           stall,
    output logic           commit_valid,
    output ooo_pkg::arn_t  commit_arn,
    output ooo_pkg::data_t commit_value
);
    import ooo_pkg::*;

    // renamed instruction and its operands
    logic  dispatch_valid;
    op_t   dispatch_op;
    data_t dispatch_imm;
    prn_t  dispatch_dest_prn, dispatch_src1_prn, dispatch_src2_prn;
    prn_t  dispatch_old_prn;
    arn_t  dispatch_arn;
    logic  src1_ready, src2_ready;
    data_t src1_value, src2_value;
    robn_t alloc_robn;
    logic  rob_full, rs_full;

    // rs to execution units
    logic  issue_valid, issue_ready;
    op_t   issue_op;
    data_t issue_a, issue_b;
    prn_t  issue_dest_prn;
    robn_t issue_robn;

    // common data bus
    logic  cdb_valid;
    prn_t  cdb_prn;
    robn_t cdb_robn;
    data_t cdb_value;

    // commit back to the free list
    logic  free_valid;
    prn_t  free_prn;

    rename_stage        i_rename (.*);
    phys_regfile        i_prf    (.*);
    reservation_station i_rs     (.*);
    exec_units          i_exec   (.*);
    reorder_buffer      i_rob    (.*);

endmodule

// ==== verilog/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

    typedef logic [`OOO_DATA_WIDTH-1:0]        data_t;
    typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arn_t;
    typedef logic [$clog2(`OOO_PHYS_REGS)-1:0] prn_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] robn_t;
    typedef logic [2:0]                        op_t;

    // alu ops
    localparam op_t OP_ADD = 3'd0;
    localparam op_t OP_SUB = 3'd1;
    localparam op_t OP_AND = 3'd2;
    localparam op_t OP_XOR = 3'd3;
    // result is the immediate
    localparam op_t OP_LI  = 3'd4;
    // low half of the product, goes to the multiplier
    localparam op_t OP_MUL = 3'd5;

endpackage

// ==== verilog/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// operand width in bits
`define OOO_DATA_WIDTH 16

// register counts, phys = arch + rob depth
`define OOO_ARCH_REGS  8
`define OOO_PHYS_REGS  16

// queue depths
`define OOO_RS_DEPTH   4
`define OOO_ROB_DEPTH  8

// cycles from issue to data bus for a multiply
`define OOO_MUL_STAGES 3

`endif

// ==== verilog/phys_regfile.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module phys_regfile (
    input  logic           clock,
    input  logic           reset,
    input  logic           dispatch_valid,
    input  ooo_pkg::prn_t  dispatch_dest_prn, dispatch_src1_prn, dispatch_src2_prn,
    input  logic           cdb_valid,
    input  ooo_pkg::prn_t  cdb_prn,
    input  ooo_pkg::data_t cdb_value,
    output logic           src1_ready,
    output ooo_pkg::data_t src1_value,
    output logic           src2_ready,
    output ooo_pkg::data_t src2_value
);
    import ooo_pkg::*;

    data_t value [`OOO_PHYS_REGS];
    logic  ready [`OOO_PHYS_REGS];
    logic  hit1, hit2;

    // bypass a result written at this same edge
    assign hit1 = cdb_valid && cdb_prn == dispatch_src1_prn;
    assign hit2 = cdb_valid && cdb_prn == dispatch_src2_prn;

    assign src1_ready = ready[dispatch_src1_prn] || hit1;
    assign src1_value = hit1 ? cdb_value : value[dispatch_src1_prn];
    assign src2_ready = ready[dispatch_src2_prn] || hit2;
    assign src2_value = hit2 ? cdb_value : value[dispatch_src2_prn];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `OOO_PHYS_REGS; i++) begin
                value[i] <= '0;
                ready[i] <= 1'b1;
            end
        end else begin
            if (cdb_valid) begin
                value[cdb_prn] <= cdb_value;
                ready[cdb_prn] <= 1'b1;
            end
            // new destination is pending until its result shows up
            if (dispatch_valid) begin
                ready[dispatch_dest_prn] <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/rename_stage.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module rename_stage (
    input  logic           clock,
    input  logic           reset,
    input  logic           insn_valid,
    input  ooo_pkg::op_t   insn_op,
    input  ooo_pkg::arn_t  insn_dest, insn_src1, insn_src2,
    input  ooo_pkg::data_t insn_imm,
    input  logic           rs_full,
    input  logic           rob_full,
    input  logic           free_valid,
    input  ooo_pkg::prn_t  free_prn,
    output logic           stall,
    output logic           dispatch_valid,
    output ooo_pkg::op_t   dispatch_op,
    output ooo_pkg::data_t dispatch_imm,
    output ooo_pkg::prn_t  dispatch_dest_prn, dispatch_src1_prn, dispatch_src2_prn,
    output ooo_pkg::prn_t  dispatch_old_prn,
    output ooo_pkg::arn_t  dispatch_arn
);
    import ooo_pkg::*;

    localparam int FREE_DEPTH = `OOO_PHYS_REGS - `OOO_ARCH_REGS;
    localparam int PTR_W      = $clog2(FREE_DEPTH);

    prn_t map_table [`OOO_ARCH_REGS];
    prn_t free_list [FREE_DEPTH];
    logic [PTR_W-1:0] free_head;
    logic [PTR_W-1:0] free_tail;

    // structural hazard, the only place it is decided
    assign stall          = rob_full || rs_full;
    assign dispatch_valid = insn_valid && !stall;
    assign dispatch_op    = insn_op;
    assign dispatch_imm   = insn_imm;
    assign dispatch_arn   = insn_dest;

    // free list cannot run dry while the ROB has room
    assign dispatch_dest_prn = free_list[free_head];
    // sources see the mapping from before this instruction
    assign dispatch_src1_prn = map_table[insn_src1];
    assign dispatch_src2_prn = map_table[insn_src2];
    assign dispatch_old_prn  = map_table[insn_dest];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `OOO_ARCH_REGS; i++) begin
                map_table[i] <= prn_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_list[i] <= prn_t'(`OOO_ARCH_REGS + i);
            end
            free_head <= '0;
            free_tail <= '0;
        end else begin
            if (dispatch_valid) begin
                map_table[insn_dest] <= free_list[free_head];
                free_head            <= free_head + 1'b1;
            end
            // register released by a commit
            if (free_valid) begin
                free_list[free_tail] <= free_prn;
                free_tail            <= free_tail + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reorder_buffer (
    input  logic           clock,
    input  logic           reset,
    input  logic           dispatch_valid,
    input  ooo_pkg::arn_t  dispatch_arn,
    input  ooo_pkg::prn_t  dispatch_dest_prn, dispatch_old_prn,
    input  logic           cdb_valid,
    input  ooo_pkg::robn_t cdb_robn,
    input  ooo_pkg::data_t cdb_value,
    output ooo_pkg::robn_t alloc_robn,
    output logic           rob_full,
    output logic           free_valid,
    output ooo_pkg::prn_t  free_prn,
    output logic           commit_valid,
    output ooo_pkg::arn_t  commit_arn,
    output ooo_pkg::data_t commit_value
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic  done [DEPTH];
    arn_t  arn [DEPTH];
    prn_t  old_prn [DEPTH];
    data_t value [DEPTH];
    robn_t head;
    robn_t tail;
    logic [CNT_W-1:0] count;

    assign alloc_robn = tail;
    assign rob_full   = count == CNT_W'(DEPTH);

    // retire the head once its result is in
    assign commit_valid = count != '0 && done[head];
    assign commit_arn   = arn[head];
    assign commit_value = value[head];
    assign free_prn     = old_prn[head];
    assign free_valid   = commit_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                done[i] <= 1'b0;
            end
        end else begin
            if (dispatch_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_robn] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(dispatch_valid) - CNT_W'(commit_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch_valid) begin
            arn[tail]     <= dispatch_arn;
            old_prn[tail] <= dispatch_old_prn;
        end
        if (cdb_valid) begin
            value[cdb_robn] <= cdb_value;
        end
    end

endmodule

// ==== verilog/reservation_station.sv ====
`timescale 1ns/1ps
`include "ooo_settings.svh"

module reservation_station (
    input  logic           clock,
    input  logic           reset,
    input  logic           dispatch_valid,
    input  ooo_pkg::op_t   dispatch_op,
    input  ooo_pkg::data_t dispatch_imm,
    input  ooo_pkg::prn_t  dispatch_dest_prn, dispatch_src1_prn, dispatch_src2_prn,
    input  logic           src1_ready,
    input  ooo_pkg::data_t src1_value,
    input  logic           src2_ready,
    input  ooo_pkg::data_t src2_value,
    input  ooo_pkg::robn_t alloc_robn,
    input  logic           issue_ready,
    input  logic           cdb_valid,
    input  ooo_pkg::prn_t  cdb_prn,
    input  ooo_pkg::data_t cdb_value,
    output logic           rs_full,
    output logic           issue_valid,
    output ooo_pkg::op_t   issue_op,
    output ooo_pkg::data_t issue_a, issue_b,
    output ooo_pkg::prn_t  issue_dest_prn,
    output ooo_pkg::robn_t issue_robn
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // slot 0 holds the oldest entry, slots at or above count are empty
    op_t   op [DEPTH];
    prn_t  dest [DEPTH], tag_a [DEPTH], tag_b [DEPTH];
    robn_t robn [DEPTH];
    logic  rdy_a [DEPTH], rdy_b [DEPTH];
    data_t val_a [DEPTH], val_b [DEPTH];
    logic  ok_a [DEPTH], ok_b [DEPTH];
    data_t cur_a [DEPTH], cur_b [DEPTH];
    logic [CNT_W-1:0] count;
    logic [IDX_W-1:0] sel;
    logic [IDX_W-1:0] wr_pos;
    logic do_issue;
    logic is_li;

    // wakeup from the data bus counts in the same cycle
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ok_a[i]  = rdy_a[i] || (cdb_valid && cdb_prn == tag_a[i]);
            ok_b[i]  = rdy_b[i] || (cdb_valid && cdb_prn == tag_b[i]);
            cur_a[i] = rdy_a[i] ? val_a[i] : cdb_value;
            cur_b[i] = rdy_b[i] ? val_b[i] : cdb_value;
        end
    end

    // oldest ready entry wins
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (i < count && ok_a[i] && ok_b[i]) begin
                issue_valid = 1'b1;
                sel         = IDX_W'(i);
            end
        end
    end

    assign issue_op       = op[sel];
    assign issue_a        = cur_a[sel];
    assign issue_b        = cur_b[sel];
    assign issue_dest_prn = dest[sel];
    assign issue_robn     = robn[sel];
    assign do_issue       = issue_valid && issue_ready;
    assign rs_full        = count == CNT_W'(DEPTH);
    assign wr_pos         = IDX_W'(count - CNT_W'(do_issue));
    assign is_li          = dispatch_op == OP_LI;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(dispatch_valid) - CNT_W'(do_issue);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < DEPTH; i++) begin
            rdy_a[i] <= ok_a[i];
            rdy_b[i] <= ok_b[i];
            val_a[i] <= cur_a[i];
            val_b[i] <= cur_b[i];
        end
        // close the gap left by the issued entry
        for (int i = 0; i < DEPTH - 1; i++) begin
            if (do_issue && i >= sel) begin
                op[i]    <= op[i+1];
                dest[i]  <= dest[i+1];
                robn[i]  <= robn[i+1];
                tag_a[i] <= tag_a[i+1];
                tag_b[i] <= tag_b[i+1];
                rdy_a[i] <= ok_a[i+1];
                rdy_b[i] <= ok_b[i+1];
                val_a[i] <= cur_a[i+1];
                val_b[i] <= cur_b[i+1];
            end
        end
        // LI needs no sources, its immediate rides in operand a
        if (dispatch_valid) begin
            op[wr_pos]    <= dispatch_op;
            dest[wr_pos]  <= dispatch_dest_prn;
            robn[wr_pos]  <= alloc_robn;
            tag_a[wr_pos] <= dispatch_src1_prn;
            tag_b[wr_pos] <= dispatch_src2_prn;
            rdy_a[wr_pos] <= src1_ready || is_li;
            rdy_b[wr_pos] <= src2_ready || is_li;
            val_a[wr_pos] <= is_li ? dispatch_imm : src1_value;
            val_b[wr_pos] <= src2_value;
        end
    end

endmodule
